// ==== hdl/accel_macros.svh ====
/*
 * Neural accelerator sizes, widths and register map
 */
`ifndef ACCEL_MACROS_SVH
`define ACCEL_MACROS_SVH

// Layer geometry
`define ACCEL_N_NEURONS     4
`define ACCEL_N_PIXELS      8

// Widths
`define ACCEL_W_DATA        32
`define ACCEL_W_OPERAND     16
`define ACCEL_W_ADDR        32

// ------------------------------
// Register offsets (byte address)
`define ACCEL_OFS_CTRL      32'h0000_0000
`define ACCEL_OFS_STATUS    32'h0000_0004
`define ACCEL_OFS_BIAS      32'h0000_0010   // One word per neuron
`define ACCEL_OFS_PIXEL     32'h0000_0020   // One word per pixel
`define ACCEL_OFS_RESULT    32'h0000_0040   // One word per neuron
`define ACCEL_OFS_WEIGHT    32'h0000_0100   // Neuron-major, n*8+p
`define ACCEL_OFS_MASK      32'h0000_0FFF   // Decoded part of the address

`endif

// ==== hdl/accel_pkg.sv ====
/*
 * Neural accelerator types
 * Bus command and response encodings, register regions, data widths
 */
`include "accel_macros.svh"

package accel_pkg;

    // Data memory request command
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Data memory response
    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // Decoded register region
    typedef enum logic [2:0] {
        RGN_CTRL, RGN_STATUS, RGN_BIAS, RGN_PIXEL, RGN_RESULT, RGN_WEIGHT, RGN_NONE
    } region_e;

    typedef logic        [`ACCEL_W_DATA-1:0]    word_t;
    typedef logic signed [`ACCEL_W_OPERAND-1:0] operand_t;  // Weight or pixel
    typedef logic signed [`ACCEL_W_DATA-1:0]    acc_t;      // Bias, sum, result
    typedef logic        [4:0]                  reg_idx_t;  // Covers 32 weight words
    typedef logic        [2:0]                  pix_idx_t;

endpackage : accel_pkg

// ==== hdl/accel_access_if.sv ====
/*
 * Decoded bus access, decode stage to register file
 * Valid for exactly one cycle per accepted request
 */
`timescale 1ns/1ps

interface accel_access_if import accel_pkg::*; ();

    logic     valid;
    mem_cmd_e cmd;
    region_e  region;
    reg_idx_t index;    // Word index inside the region
    word_t    wdata;
    logic     err;      // Unmapped or read-only target

    modport decode  (output valid, cmd, region, index, wdata, err);
    modport regfile (input  valid, cmd, region, index, wdata, err);

endinterface : accel_access_if

// ==== hdl/neuron_feed_if.sv ====
/*
 * Operand feed from the register file to the neuron layer
 */
`timescale 1ns/1ps
`include "accel_macros.svh"

interface neuron_feed_if import accel_pkg::*; ();

    logic     start;                            // One-cycle pulse
    pix_idx_t pix_idx;                          // Pixel requested by the layer
    operand_t pixel;
    operand_t weights [`ACCEL_N_NEURONS];       // Column for pix_idx
    acc_t     biases  [`ACCEL_N_NEURONS];
    logic     busy;

    modport regs  (output start, pixel, weights, biases, input  pix_idx, busy);
    modport layer (input  start, pixel, weights, biases, output pix_idx, busy);

endinterface : neuron_feed_if

// ==== hdl/accel_req_decode.sv ====
/*
 * Accelerator request decode
 * Accepts a request, maps the offset to a region and word index,
 * and registers the access for one cycle
 */
`timescale 1ns/1ps
`include "accel_macros.svh"

module accel_req_decode import accel_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  req_i,
    input  mem_cmd_e              cmd_i,
    input  word_t                 addr_i,
    input  word_t                 wdata_i,
    output logic                  req_ack_o,
    accel_access_if.decode        acc_o
);

    logic     ack_q;
    logic     accept;
    word_t    ofs;
    region_e  rgn_d;
    reg_idx_t idx_d;
    logic     err_d;

    function automatic logic in_block(word_t a, word_t base, int unsigned words);
        return (a >= base) && (a < base + word_t'(4 * words));
    endfunction

    assign ofs       = addr_i & `ACCEL_OFS_MASK;
    assign req_ack_o = ack_q;
    assign accept    = req_i & ack_q;

    // ------------------------------
    // Region and index decode
    always_comb begin
        rgn_d = RGN_NONE;
        idx_d = '0;
        if (ofs[1:0] == 2'b00) begin                           // Word aligned only
            if (ofs == `ACCEL_OFS_CTRL) begin
                rgn_d = RGN_CTRL;
            end else if (ofs == `ACCEL_OFS_STATUS) begin
                rgn_d = RGN_STATUS;
            end else if (in_block(ofs, `ACCEL_OFS_BIAS, `ACCEL_N_NEURONS)) begin
                rgn_d = RGN_BIAS;
                idx_d = reg_idx_t'((ofs - `ACCEL_OFS_BIAS) >> 2);
            end else if (in_block(ofs, `ACCEL_OFS_PIXEL, `ACCEL_N_PIXELS)) begin
                rgn_d = RGN_PIXEL;
                idx_d = reg_idx_t'((ofs - `ACCEL_OFS_PIXEL) >> 2);
            end else if (in_block(ofs, `ACCEL_OFS_RESULT, `ACCEL_N_NEURONS)) begin
                rgn_d = RGN_RESULT;
                idx_d = reg_idx_t'((ofs - `ACCEL_OFS_RESULT) >> 2);
            end else if (in_block(ofs, `ACCEL_OFS_WEIGHT,
                                  `ACCEL_N_NEURONS * `ACCEL_N_PIXELS)) begin
                rgn_d = RGN_WEIGHT;
                idx_d = reg_idx_t'((ofs - `ACCEL_OFS_WEIGHT) >> 2);
            end
        end
        // Status and results are read-only
        err_d = (rgn_d == RGN_NONE) ||
                ((cmd_i == MEM_CMD_WR) && ((rgn_d == RGN_STATUS) || (rgn_d == RGN_RESULT)));
    end

    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q       <= 1'b0;
            acc_o.valid <= 1'b0;
        end else begin
            ack_q       <= 1'b1;          // No back-pressure
            acc_o.valid <= accept;
        end
    end

    // Access payload
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_o.cmd    <= cmd_i;
            acc_o.region <= rgn_d;
            acc_o.index  <= idx_d;
            acc_o.wdata  <= wdata_i;
            acc_o.err    <= err_d;
        end
    end

endmodule : accel_req_decode

// ==== hdl/accel_reg_file.sv ====
/*
 * Accelerator register file
 * Bias, pixel, weight and result storage, bus read data and response,
 * start control and operand feed for the neuron layer
 */
`timescale 1ns/1ps
`include "accel_macros.svh"

module accel_reg_file import accel_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    accel_access_if.regfile       acc_i,
    neuron_feed_if.regs           feed_o,
    input  acc_t                  results_i [`ACCEL_N_NEURONS],
    input  logic                  done_pulse_i,
    output word_t                 rdata_o,
    output mem_resp_e             resp_o
);

    localparam int N_NRN  = `ACCEL_N_NEURONS;
    localparam int N_PIX  = `ACCEL_N_PIXELS;
    localparam int N_WGT  = N_NRN * N_PIX;
    localparam int W_NIDX = $clog2(N_NRN);
    localparam int W_OPND = `ACCEL_W_OPERAND;

    acc_t     bias_q   [N_NRN];
    operand_t pixel_q  [N_PIX];
    operand_t weight_q [N_WGT];
    acc_t     result_q [N_NRN];
    logic     done_q;

    logic     is_wr;
    logic     blocked;      // Operand write during a layer run
    logic     store_ok;
    logic     start_pulse;
    logic [W_NIDX-1:0] nidx;
    pix_idx_t pidx;

    assign is_wr    = acc_i.valid && (acc_i.cmd == MEM_CMD_WR);
    assign blocked  = is_wr && feed_o.busy &&
                      (acc_i.region inside {RGN_BIAS, RGN_PIXEL, RGN_WEIGHT});
    assign store_ok = is_wr && !acc_i.err && !feed_o.busy;
    assign nidx     = acc_i.index[W_NIDX-1:0];
    assign pidx     = pix_idx_t'(acc_i.index);

    // Start ignored while a run is in progress
    assign start_pulse  = store_ok && (acc_i.region == RGN_CTRL) && acc_i.wdata[0];
    assign feed_o.start = start_pulse;

    // ------------------------------
    // Storage
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int n = 0; n < N_NRN; n++) begin
                bias_q[n]   <= '0;
                result_q[n] <= '0;
            end
            for (int p = 0; p < N_PIX; p++) pixel_q[p] <= '0;
            for (int w = 0; w < N_WGT; w++) weight_q[w] <= '0;
            done_q <= 1'b0;
        end else begin
            if (store_ok) begin
                case (acc_i.region)
                    RGN_BIAS:   bias_q[nidx]          <= acc_i.wdata;
                    RGN_PIXEL:  pixel_q[pidx]         <= acc_i.wdata[W_OPND-1:0];
                    RGN_WEIGHT: weight_q[acc_i.index] <= acc_i.wdata[W_OPND-1:0];
                    default: ;
                endcase
            end
            if (done_pulse_i) begin
                result_q <= results_i;
                done_q   <= 1'b1;
            end
            if (start_pulse) done_q <= 1'b0;  // New run clears done
        end
    end

    // ------------------------------
    // Read mux and response
    always_comb begin
        case (acc_i.region)
            RGN_STATUS: rdata_o = {30'b0, done_q, feed_o.busy};
            RGN_BIAS:   rdata_o = bias_q[nidx];
            RGN_PIXEL:  rdata_o = {{(32 - W_OPND){pixel_q[pidx][W_OPND-1]}}, pixel_q[pidx]};
            RGN_RESULT: rdata_o = result_q[nidx];
            RGN_WEIGHT: rdata_o = {{(32 - W_OPND){weight_q[acc_i.index][W_OPND-1]}},
                                   weight_q[acc_i.index]};
            default:    rdata_o = '0;                                   // CTRL reads zero
        endcase

        if (!acc_i.valid)              resp_o = MEM_RESP_IDLE;
        else if (acc_i.err || blocked) resp_o = MEM_RESP_RDY_ER;
        else                           resp_o = MEM_RESP_RDY_OK;
    end

    // ------------------------------
    // Operand feed for the requested pixel
    assign feed_o.pixel = pixel_q[feed_o.pix_idx];

    always_comb begin
        for (int n = 0; n < N_NRN; n++) begin
            feed_o.weights[n] = weight_q[reg_idx_t'(n * N_PIX) + reg_idx_t'(feed_o.pix_idx)];
            feed_o.biases[n]  = bias_q[n];
        end
    end

endmodule : accel_reg_file

// ==== hdl/neuron_layer.sv ====
/*
 * Fully connected neuron layer
 * One pixel per cycle into all accumulators, then ReLU and capture
 */
`timescale 1ns/1ps
`include "accel_macros.svh"

module neuron_layer import accel_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    neuron_feed_if.layer          feed_i,
    output acc_t                  results_o [`ACCEL_N_NEURONS],
    output logic                  done_pulse_o
);

    localparam int N_NRN = `ACCEL_N_NEURONS;

    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        FINISH
    } layer_state_e;

    layer_state_e state_q;
    pix_idx_t     pix_q;
    acc_t         acc_q [N_NRN];

    assign feed_i.pix_idx = pix_q;
    assign feed_i.busy    = (state_q != IDLE);

    // ------------------------------
    // Sequencer
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            pix_q        <= '0;
            done_pulse_o <= 1'b0;
            for (int n = 0; n < N_NRN; n++) results_o[n] <= '0;
        end else begin
            done_pulse_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (feed_i.start) begin
                        state_q <= ACCUM;
                        pix_q   <= '0;
                    end
                end
                ACCUM: begin
                    pix_q <= pix_q + 1'b1;
                    if (pix_q == pix_idx_t'(`ACCEL_N_PIXELS - 1)) state_q <= FINISH;
                end
                FINISH: begin
                    // ReLU on the final sums
                    for (int n = 0; n < N_NRN; n++) begin
                        results_o[n] <= (acc_q[n] < 0) ? '0 : acc_q[n];
                    end
                    done_pulse_o <= 1'b1;
                    state_q      <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Accumulators, loaded with the biases at start
    always_ff @(posedge clk) begin
        for (int n = 0; n < N_NRN; n++) begin
            if ((state_q == IDLE) && feed_i.start) begin
                acc_q[n] <= feed_i.biases[n];
            end else if (state_q == ACCUM) begin
                acc_q[n] <= acc_q[n] + feed_i.weights[n] * feed_i.pixel;  // 32-bit wrap
            end
        end
    end

endmodule : neuron_layer

// ==== hdl/accel_top.sv ====
/*
 * Neural accelerator top
 * Data memory slave: request decode, register file, neuron layer
 */
`timescale 1ns/1ps
`include "accel_macros.svh"

module accel_top import accel_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    // Data memory interface
    input  logic                       dmem_req_i,
    input  mem_cmd_e                   dmem_cmd_i,
    input  logic [`ACCEL_W_ADDR-1:0]   dmem_addr_i,
    input  word_t                      dmem_wdata_i,
    output logic                       dmem_req_ack_o,
    output word_t                      dmem_rdata_o,
    output mem_resp_e                  dmem_resp_o
);

    acc_t layer_results [`ACCEL_N_NEURONS];
    logic layer_done;

    accel_access_if acc_if ();
    neuron_feed_if  feed_if ();

    // ------------------------------
    accel_req_decode u_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (dmem_req_i),
        .cmd_i        (dmem_cmd_i),
        .addr_i       (dmem_addr_i),
        .wdata_i      (dmem_wdata_i),
        .req_ack_o    (dmem_req_ack_o),
        .acc_o        (acc_if)
    );

    accel_reg_file u_regs (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .acc_i        (acc_if),
        .feed_o       (feed_if),
        .results_i    (layer_results),
        .done_pulse_i (layer_done),
        .rdata_o      (dmem_rdata_o),
        .resp_o       (dmem_resp_o)
    );

    neuron_layer u_layer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .feed_i       (feed_if),
        .results_o    (layer_results),
        .done_pulse_o (layer_done)
    );

endmodule : accel_top

// ==== bench/accel_tb.sv ====
/*
 * Neural accelerator testbench
 * LFSR operands, layer reference model and assertion-based checks
 */
`timescale 1ns/1ps
`include "accel_macros.svh"

module accel_tb import accel_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [15:0] LFSR_SEED      = 16'd88;
    localparam int          MAX_POLLS      = 64;
    localparam int          N_NRN          = `ACCEL_N_NEURONS;
    localparam int          N_PIX          = `ACCEL_N_PIXELS;

    logic      clk;
    logic      rst_n_i;
    logic      dmem_req_i;
    mem_cmd_e  dmem_cmd_i;
    word_t     dmem_addr_i;
    word_t     dmem_wdata_i;
    logic      dmem_req_ack_o;
    word_t     dmem_rdata_o;
    mem_resp_e dmem_resp_o;

    logic [15:0] lfsr_q = LFSR_SEED;
    int          errors = 0;
    int          cycles = 0;

    // Model copy of the sign-extended operands
    int bias_m [N_NRN];
    int pix_m  [N_PIX];
    int wgt_m  [N_NRN*N_PIX];

    accel_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Errors: %0d", errors);
            $display("Test failures found");
            $finish;
        end
    end

    // ------------------------------
    // Bus timing
    resp_after_accept: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dmem_req_i && dmem_req_ack_o) |=> (dmem_resp_o != MEM_RESP_IDLE))
        else begin
            errors++;
            $display("FAILED @%0t: no response one cycle after acceptance", $time);
        end

    idle_otherwise: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(dmem_req_i && dmem_req_ack_o) |=> (dmem_resp_o == MEM_RESP_IDLE))
        else begin
            errors++;
            $display("FAILED @%0t: response without an accepted request", $time);
        end

    ack_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> dmem_req_ack_o)
        else begin
            errors++;
            $display("FAILED @%0t: acknowledge low outside reset", $time);
        end

    // Taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic word_t take_bits(int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int sext16(word_t w);
        return int'($signed(w[15:0]));
    endfunction

    // Bias plus dot product with 32-bit wrap, then ReLU
    function automatic word_t expected_result(int n);
        int sum;
        sum = bias_m[n];
        for (int p = 0; p < N_PIX; p++) sum += wgt_m[n*N_PIX + p] * pix_m[p];
        return (sum < 0) ? '0 : word_t'(sum);
    endfunction

    // ------------------------------
    task automatic bus_access(input mem_cmd_e cmd, input word_t addr, input word_t wdata,
                              output word_t rdata, output mem_resp_e resp);
        int waited;
        @(posedge clk);
        dmem_req_i   <= 1'b1;
        dmem_cmd_i   <= cmd;
        dmem_addr_i  <= addr;
        dmem_wdata_i <= wdata;
        @(negedge clk);
        while (!dmem_req_ack_o) @(negedge clk);
        @(posedge clk);                                 // Accepted here
        dmem_req_i <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((dmem_resp_o == MEM_RESP_IDLE) && (waited < 4));
        rdata = dmem_rdata_o;
        resp  = dmem_resp_o;
    endtask

    task automatic write_expect(input word_t addr, input word_t data, input mem_resp_e exp);
        word_t     rd;
        mem_resp_e rs;
        bus_access(MEM_CMD_WR, addr, data, rd, rs);
        assert (rs == exp) else begin
            errors++;
            $display("FAILED @%0t: write %h got %s, expected %s", $time, addr,
                     rs.name(), exp.name());
        end
    endtask

    task automatic read_expect(input word_t addr, input word_t exp);
        word_t     rd;
        mem_resp_e rs;
        bus_access(MEM_CMD_RD, addr, '0, rd, rs);
        assert ((rs == MEM_RESP_RDY_OK) && (rd == exp)) else begin
            errors++;
            $display("FAILED @%0t: read %h got %h/%s, expected %h", $time, addr, rd,
                     rs.name(), exp);
        end
    endtask

    // Two reads accepted on consecutive edges
    task automatic read_pair(input word_t a0, input word_t e0, input word_t a1, input word_t e1);
        @(posedge clk);
        dmem_req_i  <= 1'b1;
        dmem_cmd_i  <= MEM_CMD_RD;
        dmem_addr_i <= a0;
        @(posedge clk);
        dmem_addr_i <= a1;
        @(negedge clk);
        assert ((dmem_resp_o == MEM_RESP_RDY_OK) && (dmem_rdata_o == e0)) else begin
            errors++;
            $display("FAILED @%0t: first back-to-back read %h wrong", $time, a0);
        end
        @(posedge clk);
        dmem_req_i <= 1'b0;
        @(negedge clk);
        assert ((dmem_resp_o == MEM_RESP_RDY_OK) && (dmem_rdata_o == e1)) else begin
            errors++;
            $display("FAILED @%0t: second back-to-back read %h wrong", $time, a1);
        end
    endtask

    // Negative set: negative biases, small pixels, negative weights
    task automatic load_operands(input bit negative);
        word_t d;
        for (int n = 0; n < N_NRN; n++) begin
            d = negative ? ~take_bits(16) : take_bits(32);
            write_expect(`ACCEL_OFS_BIAS + 4*n, d, MEM_RESP_RDY_OK);
            bias_m[n] = int'(d);
        end
        for (int p = 0; p < N_PIX; p++) begin
            d = negative ? take_bits(7) : take_bits(32);
            write_expect(`ACCEL_OFS_PIXEL + 4*p, d, MEM_RESP_RDY_OK);
            pix_m[p] = sext16(d);
        end
        for (int w = 0; w < N_NRN*N_PIX; w++) begin
            d = negative ? (take_bits(16) | 32'h8000) : take_bits(32);
            write_expect(`ACCEL_OFS_WEIGHT + 4*w, d, MEM_RESP_RDY_OK);
            wgt_m[w] = sext16(d);
        end
    endtask

    task automatic wait_done_and_check();
        word_t     st;
        mem_resp_e rs;
        int        polls;
        polls = 0;
        do begin
            bus_access(MEM_CMD_RD, `ACCEL_OFS_STATUS, '0, st, rs);
            polls++;
        end while (!st[1] && (polls < MAX_POLLS));
        assert (st[1]) else begin
            errors++;
            $display("Layer never reported done after %0d status polls", polls);
        end
        read_expect(`ACCEL_OFS_STATUS, 32'h2);          // Idle and done
        for (int n = 0; n < N_NRN; n++) read_expect(`ACCEL_OFS_RESULT + 4*n, expected_result(n));
    endtask

    // ------------------------------
    initial begin
        rst_n_i      = 1'b0;
        dmem_req_i   = 1'b0;
        dmem_cmd_i   = MEM_CMD_RD;
        dmem_addr_i  = '0;
        dmem_wdata_i = '0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert ((dmem_resp_o == MEM_RESP_IDLE) && !dmem_req_ack_o) else begin
            errors++;
            $display("FAILED @%0t: response not idle or acknowledge high in reset", $time);
        end
        read_expect(`ACCEL_OFS_STATUS, '0);
        read_pair(`ACCEL_OFS_STATUS, '0, `ACCEL_OFS_CTRL, '0);

        // First set with full read-back
        load_operands(1'b0);
        for (int n = 0; n < N_NRN; n++) read_expect(`ACCEL_OFS_BIAS + 4*n, word_t'(bias_m[n]));
        for (int p = 0; p < N_PIX; p++) read_expect(`ACCEL_OFS_PIXEL + 4*p, word_t'(pix_m[p]));
        for (int w = 0; w < N_NRN*N_PIX; w++) begin
            read_expect(`ACCEL_OFS_WEIGHT + 4*w, word_t'(wgt_m[w]));
        end
        read_pair(`ACCEL_OFS_BIAS, word_t'(bias_m[0]), `ACCEL_OFS_PIXEL, word_t'(pix_m[0]));
        write_expect(`ACCEL_OFS_CTRL, 32'h1, MEM_RESP_RDY_OK);
        wait_done_and_check();

        // Error responses leave state alone
        write_expect(32'h0000_0080, 32'h1234, MEM_RESP_RDY_ER);
        write_expect(`ACCEL_OFS_STATUS, 32'h0, MEM_RESP_RDY_ER);
        read_expect(`ACCEL_OFS_STATUS, 32'h2);
        write_expect(`ACCEL_OFS_RESULT, ~expected_result(0), MEM_RESP_RDY_ER);
        read_expect(`ACCEL_OFS_RESULT, expected_result(0));

        // Second set with writes during the run
        load_operands(1'b0);
        write_expect(`ACCEL_OFS_CTRL, 32'h1, MEM_RESP_RDY_OK);
        write_expect(`ACCEL_OFS_PIXEL, ~word_t'(pix_m[0]), MEM_RESP_RDY_ER);
        write_expect(`ACCEL_OFS_CTRL, 32'h1, MEM_RESP_RDY_OK);
        wait_done_and_check();
        read_expect(`ACCEL_OFS_PIXEL, word_t'(pix_m[0]));

        // Third set sums below zero
        load_operands(1'b1);
        write_expect(`ACCEL_OFS_CTRL, 32'h1, MEM_RESP_RDY_OK);
        read_expect(`ACCEL_OFS_STATUS, 32'h1);          // Done cleared by the new start
        wait_done_and_check();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : accel_tb

// ==== compile.f ====
+incdir+hdl
hdl/accel_pkg.sv
hdl/accel_access_if.sv
hdl/neuron_feed_if.sv
hdl/accel_req_decode.sv
hdl/accel_reg_file.sv
hdl/neuron_layer.sv
hdl/accel_top.sv
bench/accel_tb.sv

// ==== Makefile ====
# Verilator build and run for the neural accelerator testbench

TOP     ?= accel_tb
SIM     ?= verilator
VFLAGS  ?= --binary --assert
OBJ_DIR ?= obj_dir
FLIST   ?= compile.f

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard hdl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
